/* include/arith_consts.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic unit constants
// Operand width and multiplier depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ARITH_CONSTS_SVH
`define ARITH_CONSTS_SVH

// Operand width in bits
`define ARITH_WIDTH 16
// Register stages that fix the multiply latency
`define ARITH_MUL_STAGES 2

`endif

/* design/arith_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic unit data types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "arith_consts.svh"

package arith_types_pkg;
  // Operand, quotient or remainder
  typedef logic [`ARITH_WIDTH-1:0] word_t;
  // Full product
  typedef logic [2*`ARITH_WIDTH-1:0] dword_t;
  // Divider quotient mask, one bit per iteration
  typedef logic [`ARITH_WIDTH-1:0] step_t;
endpackage

`default_nettype wire

/* design/arith_op_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation codes and decode helpers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package arith_op_pkg;
  typedef enum logic [1:0] {
    OP_MUL_U = 2'd0,
    OP_MUL_S = 2'd1,
    OP_DIV_U = 2'd2,
    OP_DIV_S = 2'd3
  } op_t;

  function automatic logic op_is_signed(op_t op);
    return (op == OP_MUL_S) || (op == OP_DIV_S);
  endfunction

  function automatic logic op_is_div(op_t op);
    return (op == OP_DIV_U) || (op == OP_DIV_S);
  endfunction
endpackage

`default_nettype wire

/* design/div_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divider link between the signed wrapper and the core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

interface div_if;
  // Request taken by the core only while busy is low
  logic                  start;
  arith_types_pkg::word_t dividend;
  arith_types_pkg::word_t divisor;

  // Results hold from done until the next accepted start
  logic                  busy;
  logic                  done;
  arith_types_pkg::word_t quotient;
  arith_types_pkg::word_t remainder;

  modport client (
    output start, dividend, divisor,
    input  busy, done, quotient, remainder
  );

  modport core (
    input  start, dividend, divisor,
    output busy, done, quotient, remainder
  );
endinterface

`default_nettype wire

/* design/mult_pipe.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage multiplier, signed or unsigned per request
// Full double-width product, one new request per cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "arith_consts.svh"

module mult_pipe (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic                   is_signed,
  input  arith_types_pkg::word_t left,
  input  arith_types_pkg::word_t right,
  output logic                   done,
  output arith_types_pkg::dword_t product
);

  localparam int W = `ARITH_WIDTH;
  localparam int STAGES = `ARITH_MUL_STAGES;

  // One valid bit per register stage
  logic [STAGES-1:0]       valid;
  arith_types_pkg::dword_t left_ext;
  arith_types_pkg::dword_t right_ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      valid <= {valid[STAGES-2:0], go};
    end
  end

  // Stage one widens the operands so one multiplier covers both signednesses
  always_ff @(posedge clk) begin
    if (go) begin
      left_ext  <= is_signed ? {{W{left[W-1]}}, left} : {{W{1'b0}}, left};
      right_ext <= is_signed ? {{W{right[W-1]}}, right} : {{W{1'b0}}, right};
    end
  end

  // The low half of the wide product is exact in both modes
  always_ff @(posedge clk) begin
    if (valid[0]) begin
      product <= left_ext * right_ext;
    end
  end

  assign done = valid[STAGES-1];

endmodule

`default_nettype wire

/* design/div_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unsigned shift-subtract divider, one quotient bit per cycle
// Owns the busy flag and ignores start while busy
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "arith_consts.svh"

module div_core (
  input logic clk,
  input logic reset,
  div_if.core bus
);

  localparam int W = `ARITH_WIDTH;

  logic                   busy;
  logic                   accept;
  logic                   zero_dividend;
  logic                   finished;
  logic                   fits;

  // Partial remainder, divisor aligned under it, quotient and its mask
  arith_types_pkg::word_t dividend;
  logic [2*W-2:0]         divisor;
  arith_types_pkg::word_t quot;
  arith_types_pkg::step_t mask;

  assign accept        = bus.start && !busy;
  assign zero_dividend = accept && (bus.dividend == '0);
  assign finished      = busy && (mask == '0);
  assign fits          = divisor <= {{(W-1){1'b0}}, dividend};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= finished || zero_dividend;
      if (finished) begin
        busy <= 1'b0;
      end else if (accept && !zero_dividend) begin
        busy <= 1'b1;
      end
    end
  end

  // Iteration registers
  always_ff @(posedge clk) begin
    if (accept) begin
      dividend <= bus.dividend;
      divisor  <= {bus.divisor, {(W-1){1'b0}}};
      quot     <= '0;
      mask     <= {1'b1, {(W-1){1'b0}}};
    end else if (busy && (mask != '0)) begin
      if (fits) begin
        dividend <= dividend - divisor[W-1:0];
        quot     <= quot | mask;
      end
      divisor <= divisor >> 1;
      mask    <= mask >> 1;
    end
  end

  // Results cleared at start so a zero dividend reads back as zeros
  always_ff @(posedge clk) begin
    if (accept) begin
      bus.quotient  <= '0;
      bus.remainder <= '0;
    end else if (finished) begin
      bus.quotient  <= quot;
      bus.remainder <= dividend;
    end
  end

  assign bus.busy = busy;

endmodule

`default_nettype wire

/* design/div_signed.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Signed or unsigned divide around the unsigned core
// Quotient truncates, remainder takes the divisor's sign
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "arith_consts.svh"

module div_signed (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic                   is_signed,
  input  arith_types_pkg::word_t left,
  input  arith_types_pkg::word_t right,
  output logic                   busy,
  output logic                   done,
  output arith_types_pkg::word_t quotient,
  output arith_types_pkg::word_t remainder
);

  localparam int W = `ARITH_WIDTH;

  div_if bus ();

  logic                   left_neg;
  logic                   right_neg;
  logic                   left_neg_q;
  logic                   right_neg_q;
  logic                   diff_signs;
  arith_types_pkg::word_t left_mag;
  arith_types_pkg::word_t right_mag;
  arith_types_pkg::word_t right_mag_q;
  arith_types_pkg::word_t rem_adj;

  // Unsigned requests never see a negative operand
  assign left_neg  = is_signed && left[W-1];
  assign right_neg = is_signed && right[W-1];
  assign left_mag  = left_neg ? -left : left;
  assign right_mag = right_neg ? -right : right;

  // Same acceptance the core applies, so signs match the running division
  always_ff @(posedge clk) begin
    if (reset) begin
      left_neg_q  <= 1'b0;
      right_neg_q <= 1'b0;
    end else if (go && !bus.busy) begin
      left_neg_q  <= left_neg;
      right_neg_q <= right_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (go && !bus.busy) begin
      right_mag_q <= right_mag;
    end
  end

  assign bus.start    = go;
  assign bus.dividend = left_mag;
  assign bus.divisor  = right_mag;

  div_core core (
    .clk   (clk),
    .reset (reset),
    .bus   (bus)
  );

  assign diff_signs = left_neg_q ^ right_neg_q;
  assign quotient   = diff_signs ? -bus.quotient : bus.quotient;
  // Nonzero remainder with mixed signs wraps to the divisor side
  assign rem_adj    = (diff_signs && (bus.remainder != '0)) ?
                      right_mag_q - bus.remainder : bus.remainder;
  assign remainder  = right_neg_q ? -rem_adj : rem_adj;

  assign busy = bus.busy;
  assign done = bus.done;

endmodule

`default_nettype wire

/* design/arith_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer arithmetic unit, multiply and divide
// Routes each go strobe to the unit selected by op
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module arith_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    go,
  input  arith_op_pkg::op_t       op,
  input  arith_types_pkg::word_t  left,
  input  arith_types_pkg::word_t  right,
  output logic                    mul_done,
  output arith_types_pkg::dword_t product,
  output logic                    div_busy,
  output logic                    div_done,
  output arith_types_pkg::word_t  quotient,
  output arith_types_pkg::word_t  remainder
);

  logic is_div;
  logic is_signed;
  logic mul_go;
  logic div_go;

  assign is_div    = arith_op_pkg::op_is_div(op);
  assign is_signed = arith_op_pkg::op_is_signed(op);
  assign mul_go    = go && !is_div;
  // Divider drops this itself while busy
  assign div_go    = go && is_div;

  mult_pipe u_mult (
    .clk       (clk),
    .reset     (reset),
    .go        (mul_go),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .done      (mul_done),
    .product   (product)
  );

  div_signed u_div (
    .clk       (clk),
    .reset     (reset),
    .go        (div_go),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .busy      (div_busy),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

`default_nettype wire

/* test/arith_unit_assert.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe checks bound to the arithmetic unit top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module arith_unit_assert (
  input logic                   clk,
  input logic                   reset,
  input logic                   go,
  input arith_op_pkg::op_t      op,
  input arith_types_pkg::word_t left,
  input logic                   mul_done,
  input logic                   div_busy,
  input logic                   div_done
);

  logic mul_go;
  logic zero_div_go;

  assign mul_go      = go && !arith_op_pkg::op_is_div(op);
  // Accepted divide that finishes without ever raising busy
  assign zero_div_go = go && arith_op_pkg::op_is_div(op) && !div_busy && (left == '0);

  mul_latency: assert property (@(posedge clk) disable iff (reset) mul_go |-> ##2 mul_done)
    else $error("mul_done missing two cycles after a multiply go");

  div_done_source: assert property (@(posedge clk) disable iff (reset)
    div_done |-> $past(div_busy) || $past(zero_div_go))
    else $error("div_done without a running division");

  reset_clears: assert property (@(posedge clk) reset |=> !mul_done && !div_done && !div_busy)
    else $error("strobe high right after reset");

endmodule

bind arith_unit arith_unit_assert u_assert (
  .clk      (clk),
  .reset    (reset),
  .go       (go),
  .op       (op),
  .left     (left),
  .mul_done (mul_done),
  .div_busy (div_busy),
  .div_done (div_done)
);

`default_nettype wire

/* test/arith_unit_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic unit testbench
// Replays the pattern file, checks products and divide results
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "arith_consts.svh"

module arith_unit_tb;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_PATTERNS = 64;
  // Mode 0 waits for results, mode 1 issues the next line at once, mode 2 meets a busy divider
  localparam int MODE_WAIT    = 0;
  localparam int MODE_BLOCKED = 2;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    go;
  arith_op_pkg::op_t       op;
  arith_types_pkg::word_t  left;
  arith_types_pkg::word_t  right;
  logic                    mul_done;
  arith_types_pkg::dword_t product;
  logic                    div_busy;
  logic                    div_done;
  arith_types_pkg::word_t  quotient;
  arith_types_pkg::word_t  remainder;

  string                   pat_name [MAX_PATTERNS];
  int                      pat_mode [MAX_PATTERNS];
  arith_op_pkg::op_t       pat_op [MAX_PATTERNS];
  arith_types_pkg::word_t  pat_left [MAX_PATTERNS];
  arith_types_pkg::word_t  pat_right [MAX_PATTERNS];
  arith_types_pkg::dword_t pat_exp_a [MAX_PATTERNS];
  arith_types_pkg::word_t  pat_exp_b [MAX_PATTERNS];
  int                      pat_count = 0;
  bit                      loaded = 1'b0;
  // Rising edges seen so far
  int                      cycle = 0;

  // Results still owed by the DUT in issue order
  string                   mul_name_q [$];
  arith_types_pkg::dword_t mul_exp_q [$];
  int                      mul_edge_q [$];
  string                   div_name_q [$];
  arith_types_pkg::word_t  quot_exp_q [$];
  arith_types_pkg::word_t  rem_exp_q [$];
  int                      div_edge_q [$];
  bit                      div_zero_q [$];

  arith_unit dut (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .op        (op),
    .left      (left),
    .right     (right),
    .mul_done  (mul_done),
    .product   (product),
    .div_busy  (div_busy),
    .div_done  (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  always #(PERIOD/2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    stop_on_error();
  endtask

  task automatic check_product(input string name, input arith_types_pkg::dword_t expected,
                               input arith_types_pkg::dword_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input arith_types_pkg::word_t expected,
                            input arith_types_pkg::word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic load_patterns();
    int                      fd;
    int                      mode;
    int                      op_val;
    string                   line;
    string                   name;
    arith_types_pkg::word_t  l;
    arith_types_pkg::word_t  r;
    arith_types_pkg::dword_t a;
    arith_types_pkg::word_t  b;
    fd = $fopen("test/arith_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open test/arith_patterns.txt");
    end
    while (!$feof(fd) && pat_count < MAX_PATTERNS) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      // Comment lines start with #
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      if ($sscanf(line, "%s %d %h %h %h %h %h", name, mode, op_val, l, r, a, b) != 7) begin
        report_failure({"malformed pattern line: ", line});
      end
      pat_name[pat_count]  = name;
      pat_mode[pat_count]  = mode;
      pat_op[pat_count]    = arith_op_pkg::op_t'(op_val[1:0]);
      pat_left[pat_count]  = l;
      pat_right[pat_count] = r;
      pat_exp_a[pat_count] = a;
      pat_exp_b[pat_count] = b;
      pat_count++;
    end
    $fclose(fd);
    if (pat_count == 0) begin
      report_failure("the pattern file holds no patterns");
    end
  endtask

  // Drives one operation right after a rising edge
  task automatic issue_pattern(input int i);
    int issue_edge;
    issue_edge = cycle + 1;
    go    <= 1'b1;
    op    <= pat_op[i];
    left  <= pat_left[i];
    right <= pat_right[i];
    if (pat_op[i] == arith_op_pkg::OP_MUL_U || pat_op[i] == arith_op_pkg::OP_MUL_S) begin
      mul_name_q.push_back(pat_name[i]);
      mul_exp_q.push_back(pat_exp_a[i]);
      mul_edge_q.push_back(issue_edge);
    end else if (pat_mode[i] != MODE_BLOCKED) begin
      div_name_q.push_back(pat_name[i]);
      quot_exp_q.push_back(pat_exp_a[i][`ARITH_WIDTH-1:0]);
      rem_exp_q.push_back(pat_exp_b[i]);
      div_edge_q.push_back(issue_edge);
      div_zero_q.push_back(pat_left[i] == '0);
    end
  endtask

  task automatic wait_idle();
    while (mul_exp_q.size() != 0 || quot_exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin : mul_monitor
    int issue_edge;
    if (!reset && mul_done) begin
      if (mul_exp_q.size() == 0) begin
        report_failure("mul_done pulsed with no multiply in flight");
      end else begin
        issue_edge = mul_edge_q.pop_front();
        if (cycle != issue_edge + `ARITH_MUL_STAGES) begin
          report_failure({mul_name_q[0], ": mul_done not two cycles after the go edge"});
        end
        check_product(mul_name_q.pop_front(), mul_exp_q.pop_front(), product);
      end
    end
  end

  always @(negedge clk) begin : div_monitor
    int    issue_edge;
    string name;
    if (!reset && div_done) begin
      if (quot_exp_q.size() == 0) begin
        report_failure("div_done pulsed with no divide in flight");
      end else begin
        issue_edge = div_edge_q.pop_front();
        name = div_name_q.pop_front();
        // Zero dividend skips the iterations
        if (div_zero_q.pop_front() && cycle != issue_edge + 1) begin
          report_failure({name, ": zero dividend did not finish after one cycle"});
        end
        check_word({name, " quotient"}, quot_exp_q.pop_front(), quotient);
        check_word({name, " remainder"}, rem_exp_q.pop_front(), remainder);
      end
    end
  end

  initial begin : watchdog
    time limit;
    wait (loaded);
    limit = (pat_count * (`ARITH_WIDTH + 8) + RESET_CYCLES) * PERIOD;
    #(limit);
    report_failure($sformatf("timeout, operations still pending after %0t ns", limit));
  end

  initial begin : stimulus
    int gap;
    reset = 1'b1;
    go    = 1'b0;
    op    = arith_op_pkg::OP_MUL_U;
    left  = '0;
    right = '0;
    void'($urandom(66748));
    load_patterns();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < pat_count; i++) begin
      @(posedge clk);
      issue_pattern(i);
      @(negedge clk);
      if (pat_mode[i] == MODE_BLOCKED && !div_busy) begin
        report_failure({pat_name[i], ": divider idle when the blocked divide was sent"});
      end
      if (pat_mode[i] == MODE_WAIT) begin
        @(posedge clk);
        go <= 1'b0;
        wait_idle();
        gap = int'($urandom % 4);
        repeat (gap) @(posedge clk);
      end
    end
    @(posedge clk);
    go <= 1'b0;
    wait_idle();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* test/arith_patterns.txt */
# name mode op left right expect_a expect_b (hex); mode 0 waits, 1 no wait, 2 sent while busy
# op 0 mul_u, 1 mul_s, 2 div_u, 3 div_s; multiply expect_a is the product, divide is quot rem
mul_u_basic        0 0 1234 0010 00012340 0000
mul_u_max          0 0 ffff ffff fffe0001 0000
mul_s_pos_neg      0 1 0003 fffb fffffff1 0000
mul_s_neg_neg      0 1 fff0 fffd 00000030 0000
mul_s_min_min      0 1 8000 8000 40000000 0000
mul_s_min_pos      0 1 8000 0002 ffff0000 0000
burst_a            1 0 0002 0003 00000006 0000
burst_b            1 1 ffff 0002 fffffffe 0000
burst_c            1 0 0100 0100 00010000 0000
burst_d            0 1 7fff 7fff 3fff0001 0000
div_u_basic        0 2 0064 0007 0000000e 0002
div_u_small        0 2 0005 0009 00000000 0005
div_u_max          0 2 ffff 0010 00000fff 000f
div_u_big_divisor  0 2 8000 ffff 00000000 8000
div_s_pos_pos      0 3 0011 0005 00000003 0002
div_s_neg_pos      0 3 ffef 0005 0000fffd 0003
div_s_pos_neg      0 3 0011 fffb 0000fffd fffd
div_s_neg_neg      0 3 ffef fffb 00000003 fffe
div_s_exact        0 3 ffec 0005 0000fffc 0000
div_s_zero         0 3 0000 fff9 00000000 0000
busy_first         1 2 03e8 0007 0000008e 0006
busy_ignored       2 3 ffff 0003 00000000 0000
busy_mul           0 1 fffe 0005 fffffff6 0000

/* verilog.f */
+incdir+include
design/arith_types_pkg.sv
design/arith_op_pkg.sv
design/div_if.sv
design/mult_pipe.sv
design/div_core.sv
design/div_signed.sv
design/arith_unit.sv
test/arith_unit_assert.sv
test/arith_unit_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = arith_unit_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors
SRCS     = $(shell grep -v '^+' $(FILELIST)) include/arith_consts.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
